// File: bench/clock_gen.sv
module clock_gen (
  output logic clock
);

  initial
  begin
    clock = 1'b0;
  end

  always #4 clock = ~clock;   // 8 unit period

endmodule

// File: bench/core_patterns.txt
# T test name | S test expects inst_stall | I instruction word (hex)
# C wr_en index data instruction (hex), index and data unchecked when wr_en is 0
T alu_ops
I 47EB5401
I 47E1F402
I 40220403
I 40220524
I 402205A5
I 44220006
I 44220407
I 44220808
I 48220729
I 4026740A
I 4026752B
I 402B55AC
I 4426700D
I 4426780F
I 48267730
C 1 01 000000000000005A 47EB5401
C 1 02 000000000000000F 47E1F402
C 1 03 0000000000000069 40220403
C 1 04 000000000000004B 40220524
C 1 05 0000000000000000 402205A5
C 1 06 000000000000000A 44220006
C 1 07 000000000000005F 44220407
C 1 08 0000000000000055 44220808
C 1 09 00000000002D0000 48220729
C 1 0A 000000000000008D 4026740A
C 1 0B 0000000000000027 4026752B
C 1 0C 0000000000000001 402B55AC
C 1 0D 0000000000000012 4426700D
C 1 0F 0000000000000069 4426780F
C 1 10 02D0000000000000 48267730
T mul_order
I 4E1FF411
I 40203412
I 40405413
I 4D490414
I 4C300415
C 1 11 CD30000000000000 4E1FF411
C 1 12 000000000000005B 40203412
C 1 13 0000000000000011 40405413
C 1 14 0000000018C90000 4D490414
C 1 15 FD20000000000000 4C300415
T dep_chain
S
I 40203416
I 4AC09737
I 4EE07418
I 43170539
C 1 16 000000000000005B 40203416
C 1 17 00000000000005B0 4AC09737
C 1 18 0000000000001110 4EE07418
C 1 19 0000000000000B60 43170539
T zero_reg
I 4020B41F
I 43E1041A
C 0 00 0000000000000000 4020B41F
C 1 1A 000000000000005A 43E1041A
T mul_burst
S
I 47E0341C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
I 4F80741C
C 1 1C 0000000000000001 47E0341C
C 1 1C 0000000000000003 4F80741C
C 1 1C 0000000000000009 4F80741C
C 1 1C 000000000000001B 4F80741C
C 1 1C 0000000000000051 4F80741C
C 1 1C 00000000000000F3 4F80741C
C 1 1C 00000000000002D9 4F80741C
C 1 1C 000000000000088B 4F80741C
C 1 1C 00000000000019A1 4F80741C
C 1 1C 0000000000004CE3 4F80741C
T halt_illegal
I 40220FE3
I 00000555
C 0 00 0000000000000000 40220FE3
C 0 00 0000000000000000 00000555

// File: bench/core_tb.sv
module core_tb;
  import ooo_pkg::*;

  localparam int CYCLES_PER_LINE = 40;
  localparam int RESET_CYCLES    = 16;

  logic                 clock;
  logic                 rst;
  logic [31:0]          inst;
  logic                 inst_valid;
  logic                 inst_stall;
  logic                 commit_valid;
  logic                 commit_wr_en;
  logic [REG_IDX_W-1:0] commit_wr_idx;
  logic [XLEN-1:0]      commit_wr_data;
  logic [31:0]          commit_ir;
  status_t              error_status;

  // Pattern records, tagged with the test they belong to
  string                test_name  [$];
  bit                   test_stall [$];   // Test expects inst_stall to rise
  logic [31:0]          inst_word  [$];
  int                   inst_test  [$];
  logic                 exp_wr     [$];
  logic [REG_IDX_W-1:0] exp_idx    [$];
  logic [XLEN-1:0]      exp_data   [$];
  logic [31:0]          exp_ir     [$];
  int                   exp_test   [$];

  int seed            = 32'h4b4a1bc3;
  int pattern_lines   = 0;
  int watchdog_cycles = 0;
  int commit_count    = 0;
  int stall_cycles    = 0;
  int monitor_errors  = 0;
  int main_errors     = 0;
  bit expect_halted   = 1'b0;

  clock_gen clock_gen_inst (
    .clock (clock)
  );

  ooo_core ooo_core_inst (
    .clock          (clock),
    .rst            (rst),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .inst_stall     (inst_stall),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .commit_ir      (commit_ir),
    .error_status   (error_status)
  );

  ////////////////////////////////////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////////////////////////////////////
  task automatic load_patterns();
    int                   fd;
    int                   got;
    string                line;
    string                name;
    logic [31:0]          word;
    logic                 wr_v;
    logic [REG_IDX_W-1:0] idx_v;
    logic [XLEN-1:0]      data_v;
    logic [31:0]          ir_v;
    fd = $fopen("bench/core_patterns.txt", "r");
    if (fd == 0)
    begin
      main_errors++;
      $display("Pattern file bench/core_patterns.txt could not be opened");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      got  = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#")
      begin
        pattern_lines++;
        case (line[0])
          "T":
          begin
            got = $sscanf(line, "T %s", name);
            test_name.push_back(name);
            test_stall.push_back(1'b0);
          end
          "S": test_stall[test_stall.size()-1] = 1'b1;
          "I":
          begin
            got = $sscanf(line, "I %h", word);
            inst_word.push_back(word);
            inst_test.push_back(test_name.size() - 1);
          end
          "C":
          begin
            got = $sscanf(line, "C %h %h %h %h", wr_v, idx_v, data_v, ir_v);
            exp_wr.push_back(wr_v);
            exp_idx.push_back(idx_v);
            exp_data.push_back(data_v);
            exp_ir.push_back(ir_v);
            exp_test.push_back(test_name.size() - 1);
          end
          default:
          begin
            main_errors++;
            $display("Pattern line not understood: %s", line);
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////
  // Called on a rising edge, returns on the edge that accepts the word
  task automatic send_inst(input logic [31:0] word);
    int gap;
    bit taken;
    gap = $random(seed) & 3;
    if (gap != 0)
    begin
      inst_valid <= 1'b0;
      repeat (gap) @(posedge clock);
    end
    inst       <= word;
    inst_valid <= 1'b1;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clock);
      taken = !inst_stall;   // Inputs hold until the next edge
      @(posedge clock);
    end
  endtask

  task automatic run_test(input int t);
    int target;
    int errors_before;
    int stalls_before;
    target        = 0;
    errors_before = monitor_errors + main_errors;
    stalls_before = stall_cycles;
    for (int i = 0; i < exp_test.size(); i++)
      if (exp_test[i] <= t)
        target++;
    for (int i = 0; i < inst_word.size(); i++)
      if (inst_test[i] == t)
        send_inst(inst_word[i]);
    inst_valid <= 1'b0;
    wait (commit_count >= target);
    assert (!test_stall[t] || stall_cycles > stalls_before)
      else
      begin
        main_errors++;
        $display("Test %s never saw inst_stall go high", test_name[t]);
      end
    $display("Test %s finished with %0d errors", test_name[t],
             monitor_errors + main_errors - errors_before);
    @(posedge clock);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Commit monitor
  ////////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input int n, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
    monitor_errors++;
    $display("CHECK FAILED %s commit %0d %s expected %h actual %h",
             test_name[exp_test[n]], n, field, expected, actual);
  endtask

  initial
  begin
    int      n;
    status_t status_now;
    forever
    begin
      @(negedge clock);
      if (!rst && inst_valid && inst_stall)
        stall_cycles++;
      if (!rst && commit_valid)
      begin
        n = commit_count;
        assert (n < exp_ir.size())
          else
          begin
            monitor_errors++;
            $display("Commit of word %h arrived with no expected record left", commit_ir);
          end
        if (n < exp_ir.size())
        begin
          status_now = expect_halted ? HALTED_ON_HALT : NO_ERROR;
          assert (commit_ir == exp_ir[n])
            else report_mismatch(n, "ir", 64'(exp_ir[n]), 64'(commit_ir));
          assert (commit_wr_en == exp_wr[n])
            else report_mismatch(n, "wr_en", 64'(exp_wr[n]), 64'(commit_wr_en));
          if (exp_wr[n])
          begin
            assert (commit_wr_idx == exp_idx[n])
              else report_mismatch(n, "wr_idx", 64'(exp_idx[n]), 64'(commit_wr_idx));
            assert (commit_wr_data == exp_data[n])
              else report_mismatch(n, "wr_data", exp_data[n], commit_wr_data);
          end
          assert (error_status == status_now)
            else report_mismatch(n, "status", 64'(status_now), 64'(error_status));
          if (exp_ir[n] == HALT_INST)
            expect_halted = 1'b1;   // Sticky from the next cycle on
        end
        commit_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////
  initial
  begin
    int total;
    rst        <= 1'b1;
    inst       <= '0;
    inst_valid <= 1'b0;
    load_patterns();
    watchdog_cycles = CYCLES_PER_LINE * (pattern_lines + 1);
    repeat (RESET_CYCLES) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    assert (!commit_valid && !commit_wr_en && !inst_stall && error_status == NO_ERROR)
      else
      begin
        main_errors++;
        $display("Core outputs were not idle after reset");
      end
    @(posedge clock);
    for (int t = 0; t < test_name.size(); t++)
      run_test(t);
    repeat (20) @(posedge clock);   // Any stray commit shows up here
    @(negedge clock);
    assert (error_status == (expect_halted ? HALTED_ON_HALT : NO_ERROR))
      else
      begin
        main_errors++;
        $display("Final error_status %h does not match the halt history", error_status);
      end
    total = monitor_errors + main_errors;
    $display("Summary: %0d tests, %0d commits, %0d errors", test_name.size(),
             commit_count, total);
    if (total == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout after %0d cycles, commits stopped arriving", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// File: bench/rob_chk.sv
module rob_chk (
  input  logic                           clock,
  input  logic                           rst,
  input  logic                           commit_valid,
  input  logic                           commit_wr_en,
  input  logic [ooo_pkg::REG_IDX_W-1:0]  commit_wr_idx,
  input  logic                           rob_full,
  input  logic [ooo_pkg::ROB_DEPTH-1:0]  entry_valid,
  input  ooo_pkg::status_t               error_status
);
  import ooo_pkg::*;

  // Register writes ride on a commit and never target the zero register
  wr_needs_commit: assert property (@(posedge clock) disable iff (rst)
    commit_wr_en |-> (commit_valid && commit_wr_idx != REG_IDX_W'(ZERO_REG)))
    else $error("commit write without a commit or aimed at the zero register");

  halt_is_sticky: assert property (@(posedge clock) disable iff (rst)
    (error_status == HALTED_ON_HALT) |=> (error_status == HALTED_ON_HALT))
    else $error("error_status left HALTED_ON_HALT without reset");

  // Full only when every slot holds an entry, so never while empty
  full_only_when_all_valid: assert property (@(posedge clock) disable iff (rst)
    rob_full |-> (&entry_valid))
    else $error("rob_full high while some entry is free");

endmodule

bind reorder_buffer rob_chk rob_chk_inst (
  .clock         (clock),
  .rst           (rst),
  .commit_valid  (commit_valid),
  .commit_wr_en  (commit_wr_en),
  .commit_wr_idx (commit_wr_idx),
  .rob_full      (rob_full),
  .entry_valid   (entry_valid),
  .error_status  (error_status)
);

// File: common/ooo_pkg.sv
package ooo_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////
  localparam int XLEN       = 64;
  localparam int REG_IDX_W  = 5;
  localparam int NUM_REGS   = 1 << REG_IDX_W;
  localparam int ZERO_REG   = 31;   // Always reads zero
  localparam int ROB_DEPTH  = 8;
  localparam int ROB_IDX_W  = 3;
  localparam int MUL_STAGES = 4;
  localparam int MUL_CHUNK  = XLEN / MUL_STAGES;   // Multiplier bits per stage

  localparam logic [31:0] HALT_INST = 32'h555;

  //////////////////////////////////////////////////////////////////////
  // Alpha operate format encodings
  //////////////////////////////////////////////////////////////////////
  localparam logic [5:0] OP_INTA = 6'h10;   // Arithmetic
  localparam logic [5:0] OP_INTL = 6'h11;   // Logical
  localparam logic [5:0] OP_INTS = 6'h12;   // Shift
  localparam logic [5:0] OP_INTM = 6'h13;   // Multiply

  localparam logic [6:0] FN_ADDQ  = 7'h20;
  localparam logic [6:0] FN_SUBQ  = 7'h29;
  localparam logic [6:0] FN_CMPEQ = 7'h2d;
  localparam logic [6:0] FN_AND   = 7'h00;
  localparam logic [6:0] FN_BIS   = 7'h20;
  localparam logic [6:0] FN_XOR   = 7'h40;
  localparam logic [6:0] FN_SLL   = 7'h39;
  localparam logic [6:0] FN_MULQ  = 7'h20;

  typedef enum logic [2:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_CMPEQ,
    ALU_AND,
    ALU_BIS,
    ALU_XOR,
    ALU_SLL,
    ALU_MULQ
  } alu_op_t;

  typedef enum logic [3:0] {
    NO_ERROR       = 4'h0,
    HALTED_ON_HALT = 4'h2
  } status_t;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;   // Reorder buffer tag

endpackage

// File: flist.f
common/ooo_pkg.sv
source/inst_decode.sv
source/int_execute.sv
rob/reorder_buffer.sv
rob/arch_regfile.sv
source/ooo_core.sv
bench/clock_gen.sv
bench/rob_chk.sv
bench/core_tb.sv

// File: rob/arch_regfile.sv
module arch_regfile (
  input  logic                           clock,
  input  logic                           rst,
  input  logic [ooo_pkg::REG_IDX_W-1:0]  rd_idx_a,
  input  logic [ooo_pkg::REG_IDX_W-1:0]  rd_idx_b,
  input  logic                           wr_en,
  input  logic [ooo_pkg::REG_IDX_W-1:0]  wr_idx,
  input  logic [ooo_pkg::XLEN-1:0]       wr_data,
  output logic [ooo_pkg::XLEN-1:0]       rd_data_a,
  output logic [ooo_pkg::XLEN-1:0]       rd_data_b
);
  import ooo_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[wr_idx] <= wr_data;   // Written only at commit
  end

  assign rd_data_a = (rd_idx_a == REG_IDX_W'(ZERO_REG)) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == REG_IDX_W'(ZERO_REG)) ? '0 : regs[rd_idx_b];

endmodule

// File: rob/reorder_buffer.sv
module reorder_buffer (
  input  logic                           clock,
  input  logic                           rst,
  input  logic                           dispatch_valid,
  input  logic [ooo_pkg::REG_IDX_W-1:0]  dispatch_dest,
  input  logic                           dispatch_wr,
  input  logic                           dispatch_done,
  input  logic [31:0]                    dispatch_ir,
  input  logic                           alu_done,
  input  ooo_pkg::rob_idx_t              alu_tag,
  input  logic [ooo_pkg::XLEN-1:0]       alu_result,
  input  logic                           mul_done,
  input  ooo_pkg::rob_idx_t              mul_tag,
  input  logic [ooo_pkg::XLEN-1:0]       mul_result,
  output ooo_pkg::rob_idx_t              dispatch_tag,
  output logic                           rob_full,
  output logic [ooo_pkg::NUM_REGS-1:0]   pending_mask,
  output logic                           commit_valid,
  output logic                           commit_wr_en,
  output logic [ooo_pkg::REG_IDX_W-1:0]  commit_wr_idx,
  output logic [ooo_pkg::XLEN-1:0]       commit_wr_data,
  output logic [31:0]                    commit_ir,
  output ooo_pkg::status_t               error_status
);
  import ooo_pkg::*;

  rob_idx_t              head;
  rob_idx_t              tail;
  logic [ROB_DEPTH-1:0]  entry_valid;
  logic [ROB_DEPTH-1:0]  entry_done;
  logic [ROB_DEPTH-1:0]  entry_wr;
  logic [REG_IDX_W-1:0]  entry_dest   [ROB_DEPTH];
  logic [XLEN-1:0]       entry_result [ROB_DEPTH];
  logic [31:0]           entry_ir     [ROB_DEPTH];

  // Tail entry still occupied means every slot is taken
  assign rob_full     = entry_valid[tail];
  assign dispatch_tag = tail;

  always_comb
  begin
    pending_mask = '0;
    for (int i = 0; i < ROB_DEPTH; i++)
    begin
      if (entry_valid[i] && entry_wr[i])
        pending_mask[entry_dest[i]] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // In-order commit from the head
  //////////////////////////////////////////////////////////////////////
  assign commit_valid   = entry_valid[head] && entry_done[head];
  assign commit_wr_en   = commit_valid && entry_wr[head];
  assign commit_wr_idx  = entry_dest[head];
  assign commit_wr_data = entry_result[head];
  assign commit_ir      = entry_ir[head];

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      head         <= '0;
      tail         <= '0;
      entry_valid  <= '0;
      entry_done   <= '0;
      error_status <= NO_ERROR;
    end
    else
    begin
      if (dispatch_valid)
      begin
        entry_valid[tail] <= 1'b1;
        entry_done[tail]  <= dispatch_done;
        tail              <= tail + 1'b1;
      end
      if (alu_done)
        entry_done[alu_tag] <= 1'b1;
      if (mul_done)
        entry_done[mul_tag] <= 1'b1;
      if (commit_valid)
      begin
        entry_valid[head] <= 1'b0;
        head              <= head + 1'b1;
        if (commit_ir == HALT_INST)
          error_status <= HALTED_ON_HALT;   // Sticky until reset
      end
    end
  end

  // Entry payload
  always_ff @(posedge clock)
  begin
    if (dispatch_valid)
    begin
      entry_wr[tail]     <= dispatch_wr;
      entry_dest[tail]   <= dispatch_dest;
      entry_ir[tail]     <= dispatch_ir;
      entry_result[tail] <= '0;   // Halt and illegal commit zero
    end
    if (alu_done)
      entry_result[alu_tag] <= alu_result;
    if (mul_done)
      entry_result[mul_tag] <= mul_result;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module core_tb -f flist.f \
  -Mdir obj_dir -o core_tb_sim > build.log 2>&1 &&
  ./obj_dir/core_tb_sim > sim.log 2>&1 ||
  echo "Build or simulation ended abnormally, see build.log and sim.log"

grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: source/inst_decode.sv
module inst_decode (
  input  logic [31:0]                      inst,
  input  logic                             inst_valid,
  input  logic [ooo_pkg::NUM_REGS-1:0]     pending_mask,
  input  logic                             rob_full,
  input  ooo_pkg::rob_idx_t                dispatch_tag,
  input  logic [ooo_pkg::XLEN-1:0]         rd_data_a,
  input  logic [ooo_pkg::XLEN-1:0]         rd_data_b,
  output logic                             inst_stall,
  output logic [ooo_pkg::REG_IDX_W-1:0]    rd_idx_a,
  output logic [ooo_pkg::REG_IDX_W-1:0]    rd_idx_b,
  output logic                             issue_valid,
  output ooo_pkg::alu_op_t                 issue_op,
  output logic [ooo_pkg::XLEN-1:0]         opa,
  output logic [ooo_pkg::XLEN-1:0]         opb,
  output ooo_pkg::rob_idx_t                issue_tag,
  output logic                             dispatch_valid,
  output logic [ooo_pkg::REG_IDX_W-1:0]    dispatch_dest,
  output logic                             dispatch_wr,
  output logic                             dispatch_done,
  output logic [31:0]                      dispatch_ir
);
  import ooo_pkg::*;

  logic [5:0]           opcode;
  logic [6:0]           func;
  logic                 use_lit;
  logic [7:0]           lit;
  logic [REG_IDX_W-1:0] rc;
  logic                 is_op;    // One of the eight real operations
  logic                 hazard;
  logic                 accept;

  // Operate format fields
  assign opcode   = inst[31:26];
  assign rd_idx_a = inst[25:21];
  assign rd_idx_b = inst[20:16];
  assign lit      = inst[20:13];
  assign use_lit  = inst[12];
  assign func     = inst[11:5];
  assign rc       = inst[4:0];

  always_comb
  begin
    issue_op = ALU_ADDQ;
    is_op    = 1'b1;
    case (opcode)
      OP_INTA:
      begin
        case (func)
          FN_ADDQ:  issue_op = ALU_ADDQ;
          FN_SUBQ:  issue_op = ALU_SUBQ;
          FN_CMPEQ: issue_op = ALU_CMPEQ;
          default:  is_op = 1'b0;
        endcase
      end
      OP_INTL:
      begin
        case (func)
          FN_AND:  issue_op = ALU_AND;
          FN_BIS:  issue_op = ALU_BIS;
          FN_XOR:  issue_op = ALU_XOR;
          default: is_op = 1'b0;
        endcase
      end
      OP_INTS:
      begin
        issue_op = ALU_SLL;
        is_op    = (func == FN_SLL);
      end
      OP_INTM:
      begin
        issue_op = ALU_MULQ;
        is_op    = (func == FN_MULQ);
      end
      default: is_op = 1'b0;   // Halt and illegal words land here
    endcase
  end

  // Source still waiting on an uncommitted write
  assign hazard = is_op && (pending_mask[rd_idx_a] || (!use_lit && pending_mask[rd_idx_b]));

  assign inst_stall = rob_full || (inst_valid && hazard);
  assign accept     = inst_valid && !inst_stall;

  assign opa = rd_data_a;
  assign opb = use_lit ? {{(XLEN-8){1'b0}}, lit} : rd_data_b;

  assign issue_valid = accept && is_op;
  assign issue_tag   = dispatch_tag;

  assign dispatch_valid = accept;
  assign dispatch_dest  = rc;
  assign dispatch_wr    = is_op && (rc != REG_IDX_W'(ZERO_REG));
  assign dispatch_done  = !is_op;   // Halt or illegal, nothing to execute
  assign dispatch_ir    = inst;

endmodule

// File: source/int_execute.sv
module int_execute (
  input  logic                      clock,
  input  logic                      rst,
  input  logic                      issue_valid,
  input  ooo_pkg::alu_op_t          issue_op,
  input  logic [ooo_pkg::XLEN-1:0]  opa,
  input  logic [ooo_pkg::XLEN-1:0]  opb,
  input  ooo_pkg::rob_idx_t         issue_tag,
  output logic                      alu_done,
  output ooo_pkg::rob_idx_t         alu_tag,
  output logic [ooo_pkg::XLEN-1:0]  alu_result,
  output logic                      mul_done,
  output ooo_pkg::rob_idx_t         mul_tag,
  output logic [ooo_pkg::XLEN-1:0]  mul_result
);
  import ooo_pkg::*;

  logic [XLEN-1:0]       alu_value;
  logic [MUL_STAGES-1:0] mul_valid;
  rob_idx_t              mul_tag_q [MUL_STAGES];
  logic [XLEN-1:0]       mul_acc   [MUL_STAGES];
  logic [XLEN-1:0]       mul_a     [MUL_STAGES-1];   // Operands ride along
  logic [XLEN-1:0]       mul_b     [MUL_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // Single-cycle ALU
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (issue_op)
      ALU_ADDQ:  alu_value = opa + opb;
      ALU_SUBQ:  alu_value = opa - opb;
      ALU_CMPEQ: alu_value = {{(XLEN-1){1'b0}}, opa == opb};
      ALU_AND:   alu_value = opa & opb;
      ALU_BIS:   alu_value = opa | opb;
      ALU_XOR:   alu_value = opa ^ opb;
      ALU_SLL:   alu_value = opa << opb[5:0];
      default:   alu_value = '0;   // mulq goes to the pipeline
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (rst)
      alu_done <= 1'b0;
    else
      alu_done <= issue_valid && (issue_op != ALU_MULQ);
  end

  always_ff @(posedge clock)
  begin
    alu_tag    <= issue_tag;
    alu_result <= alu_value;
  end

  //////////////////////////////////////////////////////////////////////
  // Multiply pipeline
  //////////////////////////////////////////////////////////////////////
  // Each stage adds one MUL_CHUNK slice of b, low 64 bits kept
  always_ff @(posedge clock)
  begin
    if (rst)
      mul_valid <= '0;
    else
      mul_valid <= {mul_valid[MUL_STAGES-2:0], issue_valid && (issue_op == ALU_MULQ)};
  end

  always_ff @(posedge clock)
  begin
    mul_tag_q[0] <= issue_tag;
    mul_a[0]     <= opa;
    mul_b[0]     <= opb;
    mul_acc[0]   <= opa * opb[MUL_CHUNK-1:0];
    for (int s = 1; s < MUL_STAGES; s++)
    begin
      mul_tag_q[s] <= mul_tag_q[s-1];
      mul_acc[s]   <= mul_acc[s-1]
                      + ((mul_a[s-1] * mul_b[s-1][s*MUL_CHUNK +: MUL_CHUNK]) << (s*MUL_CHUNK));
    end
    for (int s = 1; s < MUL_STAGES-1; s++)
    begin
      mul_a[s] <= mul_a[s-1];
      mul_b[s] <= mul_b[s-1];
    end
  end

  assign mul_done   = mul_valid[MUL_STAGES-1];
  assign mul_tag    = mul_tag_q[MUL_STAGES-1];
  assign mul_result = mul_acc[MUL_STAGES-1];

endmodule

// File: source/ooo_core.sv
module ooo_core (
  input  logic                           clock,
  input  logic                           rst,
  input  logic [31:0]                    inst,
  input  logic                           inst_valid,
  output logic                           inst_stall,
  output logic                           commit_valid,
  output logic                           commit_wr_en,
  output logic [ooo_pkg::REG_IDX_W-1:0]  commit_wr_idx,
  output logic [ooo_pkg::XLEN-1:0]       commit_wr_data,
  output logic [31:0]                    commit_ir,
  output ooo_pkg::status_t               error_status
);
  import ooo_pkg::*;

  // Decode and register file
  logic [REG_IDX_W-1:0] rd_idx_a;
  logic [REG_IDX_W-1:0] rd_idx_b;
  logic [XLEN-1:0]      rd_data_a;
  logic [XLEN-1:0]      rd_data_b;

  // Issue to execute
  logic                 issue_valid;
  alu_op_t              issue_op;
  logic [XLEN-1:0]      opa;
  logic [XLEN-1:0]      opb;
  rob_idx_t             issue_tag;

  // Dispatch into the reorder buffer
  logic                 dispatch_valid;
  logic [REG_IDX_W-1:0] dispatch_dest;
  logic                 dispatch_wr;
  logic                 dispatch_done;
  logic [31:0]          dispatch_ir;
  rob_idx_t             dispatch_tag;
  logic                 rob_full;
  logic [NUM_REGS-1:0]  pending_mask;

  // Completions
  logic                 alu_done;
  rob_idx_t             alu_tag;
  logic [XLEN-1:0]      alu_result;
  logic                 mul_done;
  rob_idx_t             mul_tag;
  logic [XLEN-1:0]      mul_result;

  inst_decode decode_inst (
    .inst           (inst),
    .inst_valid     (inst_valid),
    .pending_mask   (pending_mask),
    .rob_full       (rob_full),
    .dispatch_tag   (dispatch_tag),
    .rd_data_a      (rd_data_a),
    .rd_data_b      (rd_data_b),
    .inst_stall     (inst_stall),
    .rd_idx_a       (rd_idx_a),
    .rd_idx_b       (rd_idx_b),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .opa            (opa),
    .opb            (opb),
    .issue_tag      (issue_tag),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_wr    (dispatch_wr),
    .dispatch_done  (dispatch_done),
    .dispatch_ir    (dispatch_ir)
  );

  int_execute execute_inst (
    .clock       (clock),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .opa         (opa),
    .opb         (opb),
    .issue_tag   (issue_tag),
    .alu_done    (alu_done),
    .alu_tag     (alu_tag),
    .alu_result  (alu_result),
    .mul_done    (mul_done),
    .mul_tag     (mul_tag),
    .mul_result  (mul_result)
  );

  reorder_buffer rob_inst (
    .clock          (clock),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_wr    (dispatch_wr),
    .dispatch_done  (dispatch_done),
    .dispatch_ir    (dispatch_ir),
    .alu_done       (alu_done),
    .alu_tag        (alu_tag),
    .alu_result     (alu_result),
    .mul_done       (mul_done),
    .mul_tag        (mul_tag),
    .mul_result     (mul_result),
    .dispatch_tag   (dispatch_tag),
    .rob_full       (rob_full),
    .pending_mask   (pending_mask),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .commit_ir      (commit_ir),
    .error_status   (error_status)
  );

  arch_regfile regfile_inst (
    .clock     (clock),
    .rst       (rst),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .wr_en     (commit_wr_en),
    .wr_idx    (commit_wr_idx),
    .wr_data   (commit_wr_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

endmodule
